// ==== Makefile ====
# Verilator flow for the FTQ frontend
VERILATOR ?= verilator
TOP       ?= ftq_frontend_tb
RTL_TOP   ?= ftq_frontend_top
FILELIST  ?= ftq_frontend.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "All checks passed" $(LOG); then \
		echo "simulation result: pass"; \
	else \
		echo "simulation result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/ftq_entry_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ftq_defs.svh"

module ftq_entry_ram #(
    parameter type entry_t = logic [7:0],
    parameter int NUM_WR = 1,
    parameter int NUM_RD = 1
) (
    input  wire                                 clk,
    input  wire  [NUM_WR-1:0]                   i_we,
    input  ftq_pkg::ftq_idx_t [NUM_WR-1:0]      i_waddr,
    input  entry_t [NUM_WR-1:0]                 i_wdata,
    input  ftq_pkg::ftq_idx_t [NUM_RD-1:0]      i_raddr,
    output entry_t [NUM_RD-1:0]                 o_rdata
);

    // one entry per queue slot
    entry_t mem [`FTQ_SIZE];

    // ports applied in order
    // so the highest enabled port lands last
    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WR; w++) begin
            if (i_we[w]) begin
                mem[i_waddr[w]] <= i_wdata[w];
            end
        end
    end

    // combinational reads
    for (genvar r = 0; r < NUM_RD; r++) begin : g_rd
        assign o_rdata[r] = mem[i_raddr[r]];
    end

endmodule

`default_nettype wire

// ==== design/ftq_frontend_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ftq_defs.svh"

module ftq_frontend_top (
    input  wire                                         clk,
    input  wire                                         rst,
    input  wire                                         i_pred_req,
    output logic                                        o_ftq_rdy,
    input  ftq_pkg::ftq_fetch_info_t                    i_pred_info,
    output logic                                        o_icache_req,
    input  wire                                         i_icache_rdy,
    output ftq_pkg::ftq_icache_req_t                    o_icache_info,
    input  wire  [`FTQ_BRU_NUM-1:0]                     i_branch_wb_vld,
    input  ftq_pkg::ftq_branch_wb_t [`FTQ_BRU_NUM-1:0]  i_branch_wb,
    input  wire                                         i_commit_vld,
    input  ftq_pkg::ftq_idx_t                           i_commit_idx,
    input  wire                                         i_squash_vld,
    input  ftq_pkg::ftq_idx_t                           i_squash_idx,
    input  wire                                         i_bpu_done,
    output logic                                        o_bpu_update,
    output ftq_pkg::ftq_bpu_update_t                    o_bpu_info
);

    import ftq_pkg::*;

    // fetch storage wiring, read 0 at fetch_ptr, read 1 at commit_ptr
    logic [0:0]                 fetch_we;
    ftq_idx_t [0:0]             fetch_waddr;
    ftq_fetch_info_t [0:0]      fetch_wdata;
    ftq_idx_t [1:0]             fetch_raddr;
    ftq_fetch_info_t [1:0]      fetch_rdata;

    // branch storage wiring, port 0 clears on insert
    logic [`FTQ_BRU_NUM:0]      branch_we;
    ftq_idx_t [`FTQ_BRU_NUM:0]  branch_waddr;
    ftq_branch_info_t [`FTQ_BRU_NUM:0] branch_wdata;
    ftq_idx_t [0:0]             branch_raddr;
    ftq_branch_info_t [0:0]     branch_rdata;

    ftq_queue ftq_queue_inst (
        .clk              (clk),
        .rst              (rst),
        .i_pred_req       (i_pred_req),
        .o_ftq_rdy        (o_ftq_rdy),
        .i_pred_info      (i_pred_info),
        .o_icache_req     (o_icache_req),
        .i_icache_rdy     (i_icache_rdy),
        .i_branch_wb_vld  (i_branch_wb_vld),
        .i_branch_wb      (i_branch_wb),
        .i_commit_vld     (i_commit_vld),
        .i_commit_idx     (i_commit_idx),
        .i_squash_vld     (i_squash_vld),
        .i_squash_idx     (i_squash_idx),
        .i_bpu_done       (i_bpu_done),
        .i_commit_mispred (branch_rdata[0].mispred),
        .o_bpu_update     (o_bpu_update),
        .o_fetch_we       (fetch_we),
        .o_fetch_waddr    (fetch_waddr),
        .o_fetch_wdata    (fetch_wdata),
        .o_fetch_raddr    (fetch_raddr),
        .o_branch_we      (branch_we),
        .o_branch_waddr   (branch_waddr),
        .o_branch_wdata   (branch_wdata),
        .o_branch_raddr   (branch_raddr)
    );

    ftq_entry_ram #(
        .entry_t (ftq_fetch_info_t),
        .NUM_WR  (1),
        .NUM_RD  (2)
    ) fetch_ram_inst (
        .clk     (clk),
        .i_we    (fetch_we),
        .i_waddr (fetch_waddr),
        .i_wdata (fetch_wdata),
        .i_raddr (fetch_raddr),
        .o_rdata (fetch_rdata)
    );

    ftq_entry_ram #(
        .entry_t (ftq_branch_info_t),
        .NUM_WR  (`FTQ_BRU_NUM + 1),
        .NUM_RD  (1)
    ) branch_ram_inst (
        .clk     (clk),
        .i_we    (branch_we),
        .i_waddr (branch_waddr),
        .i_wdata (branch_wdata),
        .i_raddr (branch_raddr),
        .o_rdata (branch_rdata)
    );

    ftq_update_gen ftq_update_gen_inst (
        .i_fetch_info   (fetch_rdata[1]),
        .i_branch_info  (branch_rdata[0]),
        .o_bpu_info     (o_bpu_info),
        .o_icache_info  (o_icache_info),
        .i_icache_fetch (fetch_rdata[0])
    );

endmodule

`default_nettype wire

// ==== design/ftq_pkg.sv ====
`default_nettype none

`include "ftq_defs.svh"

package ftq_pkg;

    // one queue slot
    typedef logic [`FTQ_IDX_W-1:0] ftq_idx_t;

    // predicted block, written on insert
    typedef struct packed {
        logic [`FTQ_ADDR_W-1:0] start_addr;
        logic [`FTQ_ADDR_W-1:0] end_addr;
        // predicted target
        logic [`FTQ_ADDR_W-1:0] next_addr;
        logic                   ftb_hit;
        logic [1:0]             ftb_counter;
    } ftq_fetch_info_t;

    // resolution of a block from the backend
    typedef struct packed {
        logic                   mispred;
        logic                   taken;
        logic [`FTQ_ADDR_W-1:0] target_addr;
    } ftq_branch_info_t;

    // one writeback port, slot plus resolution
    typedef struct packed {
        ftq_idx_t               ftq_idx;
        logic                   mispred;
        logic                   taken;
        logic [`FTQ_ADDR_W-1:0] target_addr;
    } ftq_branch_wb_t;

    // request to the instruction cache
    typedef struct packed {
        logic [`FTQ_ADDR_W-1:0] start_addr;
        logic [`FTQ_BSIZE_W-1:0] block_size;
    } ftq_icache_req_t;

    // predictor update for a mispredicted block
    typedef struct packed {
        logic [`FTQ_ADDR_W-1:0] start_addr;
        logic [`FTQ_ADDR_W-1:0] target_addr;
        logic                   taken;
        logic [1:0]             new_counter;
    } ftq_bpu_update_t;

endpackage

`default_nettype wire

// ==== design/ftq_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ftq_defs.svh"

module ftq_queue (
    input  wire                                         clk,
    input  wire                                         rst,
    // predictor insert
    input  wire                                         i_pred_req,
    output logic                                        o_ftq_rdy,
    input  ftq_pkg::ftq_fetch_info_t                    i_pred_info,
    // instruction cache
    output logic                                        o_icache_req,
    input  wire                                         i_icache_rdy,
    // backend writeback
    input  wire  [`FTQ_BRU_NUM-1:0]                     i_branch_wb_vld,
    input  ftq_pkg::ftq_branch_wb_t [`FTQ_BRU_NUM-1:0]  i_branch_wb,
    // commit and squash
    input  wire                                         i_commit_vld,
    input  ftq_pkg::ftq_idx_t                           i_commit_idx,
    input  wire                                         i_squash_vld,
    input  ftq_pkg::ftq_idx_t                           i_squash_idx,
    // predictor update
    input  wire                                         i_bpu_done,
    input  wire                                         i_commit_mispred,
    output logic                                        o_bpu_update,
    // fetch storage
    output logic [0:0]                                  o_fetch_we,
    output ftq_pkg::ftq_idx_t [0:0]                     o_fetch_waddr,
    output ftq_pkg::ftq_fetch_info_t [0:0]              o_fetch_wdata,
    output ftq_pkg::ftq_idx_t [1:0]                     o_fetch_raddr,
    // branch storage
    output logic [`FTQ_BRU_NUM:0]                       o_branch_we,
    output ftq_pkg::ftq_idx_t [`FTQ_BRU_NUM:0]          o_branch_waddr,
    output ftq_pkg::ftq_branch_info_t [`FTQ_BRU_NUM:0]  o_branch_wdata,
    output ftq_pkg::ftq_idx_t [0:0]                     o_branch_raddr
);

    import ftq_pkg::*;

    // count must reach FTQ_SIZE itself
    localparam int CNT_W = `FTQ_IDX_W + 1;

    ftq_idx_t pred_ptr;
    ftq_idx_t fetch_ptr;
    ftq_idx_t commit_ptr;
    // retire up to here, exclusive
    ftq_idx_t commit_thre;
    logic [CNT_W-1:0] count;
    // inserted but not yet sent to the cache
    logic [CNT_W-1:0] pend_cnt;

    logic pred_fire;
    logic fetch_fire;
    logic do_commit;
    logic retire;

    function automatic ftq_idx_t ptr_inc(input ftq_idx_t p);
        if (p == ftq_idx_t'(`FTQ_SIZE - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign o_ftq_rdy = (count != CNT_W'(`FTQ_SIZE));

    // pending count stands in for fetch_ptr != pred_ptr
    // and still tells a full unfetched queue apart
    assign o_icache_req = (pend_cnt != '0);

    // a squash cycle drops inserts and fetch moves
    assign pred_fire  = i_pred_req & o_ftq_rdy & ~i_squash_vld;
    assign fetch_fire = o_icache_req & i_icache_rdy & ~i_squash_vld;

    // commit side
    assign do_commit    = (commit_ptr != commit_thre);
    assign o_bpu_update = do_commit & i_commit_mispred;
    // clean entries leave at once, mispredicted ones wait for the predictor
    assign retire       = do_commit & (~i_commit_mispred | i_bpu_done);

    // fetch storage, insert at pred_ptr
    assign o_fetch_we[0]    = pred_fire;
    assign o_fetch_waddr[0] = pred_ptr;
    assign o_fetch_wdata[0] = i_pred_info;
    // read 0 feeds the cache, read 1 the update
    assign o_fetch_raddr[0] = fetch_ptr;
    assign o_fetch_raddr[1] = commit_ptr;

    // branch port 0 clears the slot of a new block
    assign o_branch_we[0]    = pred_fire;
    assign o_branch_waddr[0] = pred_ptr;
    assign o_branch_wdata[0] = '0;

    // remaining ports carry backend writebacks
    for (genvar p = 0; p < `FTQ_BRU_NUM; p++) begin : g_wb
        assign o_branch_we[p+1]    = i_branch_wb_vld[p];
        assign o_branch_waddr[p+1] = i_branch_wb[p].ftq_idx;
        assign o_branch_wdata[p+1] = '{
            mispred:     i_branch_wb[p].mispred,
            taken:       i_branch_wb[p].taken,
            target_addr: i_branch_wb[p].target_addr
        };
    end

    // mispred flag of the slot being retired
    assign o_branch_raddr[0] = commit_ptr;

    always_ff @(posedge clk) begin
        if (rst) begin
            pred_ptr    <= '0;
            fetch_ptr   <= '0;
            commit_ptr  <= '0;
            commit_thre <= '0;
            count       <= '0;
            pend_cnt    <= '0;
        end else begin
            if (i_commit_vld) begin
                commit_thre <= i_commit_idx;
            end
            if (retire) begin
                commit_ptr <= ptr_inc(commit_ptr);
            end

            if (i_squash_vld) begin
                // rewind to just after the mispredicted block
                pred_ptr  <= ptr_inc(i_squash_idx);
                fetch_ptr <= ptr_inc(i_squash_idx);
                pend_cnt  <= '0;
                // blocks from commit_ptr through the squash slot stay
                count <= CNT_W'(ftq_idx_t'(i_squash_idx - commit_ptr))
                         + CNT_W'(1) - CNT_W'(retire);
            end else begin
                if (pred_fire) begin
                    pred_ptr <= ptr_inc(pred_ptr);
                end
                if (fetch_fire) begin
                    fetch_ptr <= ptr_inc(fetch_ptr);
                end
                pend_cnt <= pend_cnt + CNT_W'(pred_fire) - CNT_W'(fetch_fire);
                count    <= count + CNT_W'(pred_fire) - CNT_W'(retire);
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/ftq_update_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ftq_defs.svh"

module ftq_update_gen (
    input  ftq_pkg::ftq_fetch_info_t   i_fetch_info,
    input  ftq_pkg::ftq_branch_info_t  i_branch_info,
    output ftq_pkg::ftq_bpu_update_t   o_bpu_info,
    output ftq_pkg::ftq_icache_req_t   o_icache_info,
    input  ftq_pkg::ftq_fetch_info_t   i_icache_fetch
);

    import ftq_pkg::*;

    logic [1:0] old_ctr;
    logic [1:0] new_ctr;

    assign old_ctr = i_fetch_info.ftb_counter;

    // two-bit saturating counter
    always_comb begin
        if (i_branch_info.taken) begin
            // count up, stop at strongly taken
            new_ctr = (old_ctr == 2'b11) ? 2'b11 : old_ctr + 2'b01;
        end else begin
            // count down, stop at strongly not taken
            new_ctr = (old_ctr == 2'b00) ? 2'b00 : old_ctr - 2'b01;
        end
    end

    // update for the block at commit_ptr
    assign o_bpu_info = '{
        start_addr:  i_fetch_info.start_addr,
        target_addr: i_branch_info.target_addr,
        taken:       i_branch_info.taken,
        new_counter: new_ctr
    };

    // cache request for the block at fetch_ptr
    // size never exceeds FTQ_MAX_BLOCK, fits the narrow field
    assign o_icache_info = '{
        start_addr: i_icache_fetch.start_addr,
        block_size: `FTQ_BSIZE_W'(i_icache_fetch.end_addr - i_icache_fetch.start_addr)
    };

endmodule

`default_nettype wire

// ==== ftq_frontend.f ====
+incdir+include
design/ftq_pkg.sv
design/ftq_entry_ram.sv
design/ftq_queue.sv
design/ftq_update_gen.sv
design/ftq_frontend_top.sv
tb/ftq_frontend_assert.sv
tb/ftq_frontend_tb.sv

// ==== include/ftq_defs.svh ====
`ifndef FTQ_DEFS_SVH
`define FTQ_DEFS_SVH

// address width of the frontend
`define FTQ_ADDR_W 32

// queue depth in fetch blocks
`define FTQ_SIZE 8

// bits needed to name one queue slot
`define FTQ_IDX_W 3

// backend branch units that write back
`define FTQ_BRU_NUM 2

// largest fetch block, in bytes
// block size field must hold this value
`define FTQ_MAX_BLOCK 64

// width of the cache request size field
`define FTQ_BSIZE_W 7

`endif

// ==== tb/ftq_frontend_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ftq_defs.svh"

module ftq_frontend_assert (
    input  wire                                         clk,
    input  wire                                         rst,
    input  wire                                         i_fetch_we,
    input  ftq_pkg::ftq_fetch_info_t                    i_fetch_wdata,
    input  wire  [`FTQ_BRU_NUM-1:0]                     i_wb_vld,
    input  ftq_pkg::ftq_branch_wb_t [`FTQ_BRU_NUM-1:0]  i_wb,
    input  wire                                         i_ftq_rdy,
    input  wire  [`FTQ_IDX_W:0]                         i_count,
    input  ftq_pkg::ftq_idx_t                           i_pred_ptr,
    input  wire                                         i_commit_vld,
    input  wire                                         i_bpu_update,
    input  ftq_pkg::ftq_idx_t                           i_commit_ptr
);

    import ftq_pkg::*;

    // size of a block headed for the cache
    logic [`FTQ_ADDR_W-1:0] blk_size;

    assign blk_size = i_fetch_wdata.end_addr - i_fetch_wdata.start_addr;

    // every stored block must make a legal cache request
    a_blk_size : assert property (@(posedge clk) disable iff (rst)
        i_fetch_we |-> (blk_size != '0 && blk_size <= `FTQ_MAX_BLOCK))
        else $error("fetch block size %0d out of range", blk_size);

    // two units never resolve the same slot at once
    a_wb_idx : assert property (@(posedge clk) disable iff (rst)
        (&i_wb_vld) |-> (i_wb[0].ftq_idx != i_wb[1].ftq_idx))
        else $error("writeback ports share slot %0d", i_wb[0].ftq_idx);

    // insert caught up with the oldest slot, so every slot is held
    a_full : assert property (@(posedge clk) disable iff (rst)
        (i_pred_ptr == i_commit_ptr && i_count != '0) |-> !i_ftq_rdy)
        else $error("queue full but ready high");

    // an update starts only on a new threshold or a step of commit_ptr
    a_upd : assert property (@(posedge clk) disable iff (rst)
        $rose(i_bpu_update) |->
            ($past(i_commit_vld) || ($past(i_commit_ptr) != i_commit_ptr)))
        else $error("predictor update with no pending commit");

endmodule

bind ftq_queue ftq_frontend_assert ftq_frontend_assert_inst (
    .clk           (clk),
    .rst           (rst),
    .i_fetch_we    (o_fetch_we[0]),
    .i_fetch_wdata (o_fetch_wdata[0]),
    .i_wb_vld      (i_branch_wb_vld),
    .i_wb          (i_branch_wb),
    .i_ftq_rdy     (o_ftq_rdy),
    .i_count       (count),
    .i_pred_ptr    (pred_ptr),
    .i_commit_vld  (i_commit_vld),
    .i_bpu_update  (o_bpu_update),
    .i_commit_ptr  (commit_ptr)
);

`default_nettype wire

// ==== tb/ftq_frontend_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ftq_defs.svh"

module ftq_frontend_tb;

    import ftq_pkg::*;

    localparam int NUM_BLK  = 10;
    localparam int WAIT_MAX = 400;

    // one predicted block and its resolution
    typedef struct packed {
        logic [31:0] start_addr;
        logic [31:0] end_addr;
        logic [1:0]  ctr;
        logic        taken;
        logic        mispred;
        logic [31:0] target;
    } blk_row_t;

    // start, end, stored counter, taken, mispred, target
    blk_row_t blk_table [NUM_BLK] = '{
        '{32'h0000_1000, 32'h0000_1020, 2'd1, 1'b0, 1'b0, 32'h0000_1020},
        '{32'h0000_1020, 32'h0000_1040, 2'd3, 1'b1, 1'b1, 32'h0000_2000},
        '{32'h0000_2000, 32'h0000_2010, 2'd0, 1'b0, 1'b1, 32'h0000_2010},
        '{32'h0000_2010, 32'h0000_2050, 2'd2, 1'b1, 1'b0, 32'h0000_3000},
        '{32'h0000_3000, 32'h0000_3008, 2'd1, 1'b0, 1'b0, 32'h0000_3008},
        '{32'h0000_3008, 32'h0000_3048, 2'd1, 1'b1, 1'b1, 32'h0000_4000},
        '{32'h0000_4000, 32'h0000_4004, 2'd2, 1'b0, 1'b1, 32'h0000_4004},
        '{32'h0000_4004, 32'h0000_4040, 2'd0, 1'b1, 1'b0, 32'h0000_5000},
        '{32'h0000_5000, 32'h0000_5030, 2'd3, 1'b0, 1'b0, 32'h0000_5030},
        '{32'h0000_5030, 32'h0000_5070, 2'd0, 1'b1, 1'b1, 32'h0000_6000}
    };

    logic                               clk;
    logic                               rst;
    logic                               i_pred_req;
    ftq_fetch_info_t                    i_pred_info;
    logic                               i_icache_rdy;
    logic [`FTQ_BRU_NUM-1:0]            i_branch_wb_vld;
    ftq_branch_wb_t [`FTQ_BRU_NUM-1:0]  i_branch_wb;
    logic                               i_commit_vld;
    ftq_idx_t                           i_commit_idx;
    logic                               i_squash_vld;
    ftq_idx_t                           i_squash_idx;
    logic                               i_bpu_done;
    logic                               o_ftq_rdy;
    logic                               o_icache_req;
    logic                               o_bpu_update;
    ftq_icache_req_t                    o_icache_info;
    ftq_bpu_update_t                    o_bpu_info;

    // expected cache requests and predictor updates, oldest first
    ftq_icache_req_t exp_req[$];
    ftq_bpu_update_t exp_upd[$];
    ftq_icache_req_t got_req;
    ftq_bpu_update_t got_upd;
    ftq_bpu_update_t held_info;
    logic            held_vld;
    logic            cache_hold;
    int              bpu_wait;
    int              fetch_cnt;
    int              checks;
    int              errors;

    ftq_frontend_top ftq_frontend_top_inst (
        .clk             (clk),
        .rst             (rst),
        .i_pred_req      (i_pred_req),
        .o_ftq_rdy       (o_ftq_rdy),
        .i_pred_info     (i_pred_info),
        .o_icache_req    (o_icache_req),
        .i_icache_rdy    (i_icache_rdy),
        .o_icache_info   (o_icache_info),
        .i_branch_wb_vld (i_branch_wb_vld),
        .i_branch_wb     (i_branch_wb),
        .i_commit_vld    (i_commit_vld),
        .i_commit_idx    (i_commit_idx),
        .i_squash_vld    (i_squash_vld),
        .i_squash_idx    (i_squash_idx),
        .i_bpu_done      (i_bpu_done),
        .o_bpu_update    (o_bpu_update),
        .o_bpu_info      (o_bpu_info)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // saturating two-bit counter step
    function automatic logic [1:0] next_ctr(input logic [1:0] ctr, input logic taken);
        int c;
        c = taken ? int'(ctr) + 1 : int'(ctr) - 1;
        if (c > 3) c = 3;
        if (c < 0) c = 0;
        return 2'(c);
    endfunction

    task automatic end_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    task automatic fail_timeout(input string what);
        errors++;
        $display("timeout at %0t while waiting for %s", $time, what);
        end_run();
    endtask

    task automatic check_val(input string name, input logic [127:0] exp,
                             input logic [127:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED t=%0t %s expected %0h actual %0h", $time, name, exp, act);
        end
    endtask

    // one clock, back at the drive point
    task automatic step();
        @(posedge clk);
        #10;
    endtask

    // hold a block on the predictor port until the queue takes it
    task automatic insert_blk(input int row);
        blk_row_t r;
        int n;
        r = blk_table[row];
        n = 0;
        i_pred_req  = 1'b1;
        i_pred_info = '{start_addr: r.start_addr, end_addr: r.end_addr,
                        next_addr: r.target, ftb_hit: 1'b1, ftb_counter: r.ctr};
        @(negedge clk);
        while (!o_ftq_rdy && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (!o_ftq_rdy) fail_timeout("predictor insert");
        step();
        i_pred_req = 1'b0;
        exp_req.push_back('{start_addr: r.start_addr,
                            block_size: `FTQ_BSIZE_W'(r.end_addr - r.start_addr)});
    endtask

    // backend resolution of a table row on one port
    task automatic set_wb(input int port, input int row);
        i_branch_wb_vld[port] = 1'b1;
        i_branch_wb[port] = '{ftq_idx: ftq_idx_t'(row % `FTQ_SIZE),
                              mispred: blk_table[row].mispred,
                              taken: blk_table[row].taken,
                              target_addr: blk_table[row].target};
    endtask

    task automatic commit_to(input int idx);
        i_commit_vld = 1'b1;
        i_commit_idx = ftq_idx_t'(idx);
        step();
        i_commit_vld = 1'b0;
    endtask

    task automatic wait_fetched(input int n);
        int t;
        t = 0;
        while (fetch_cnt < n && t < WAIT_MAX) begin
            step();
            t++;
        end
        if (fetch_cnt < n) fail_timeout("cache requests");
    endtask

    // wait until only the given number of updates is still expected
    task automatic wait_updates(input int left);
        int t;
        t = 0;
        while (exp_upd.size() > left && t < WAIT_MAX) begin
            step();
            t++;
        end
        if (exp_upd.size() > left) fail_timeout("predictor updates");
    endtask

    // cache and predictor stubs, one random stream
    initial begin
        void'($urandom(70));
        forever begin
            @(posedge clk);
            // hold flag taken at the edge, before the main process moves it
            if (cache_hold) begin
                #10;
                i_icache_rdy = 1'b0;
            end else begin
                #10;
                i_icache_rdy = ($urandom_range(0, 3) != 0);
            end
            // late done, one to four cycles after the update shows
            if (i_bpu_done || !o_bpu_update) begin
                i_bpu_done = 1'b0;
                bpu_wait   = $urandom_range(1, 4);
            end else if (bpu_wait == 0) begin
                i_bpu_done = 1'b1;
            end else begin
                bpu_wait--;
            end
        end
    end

    // monitor mid cycle, inputs and outputs both settled
    always @(negedge clk) begin
        if (!rst && o_icache_req && i_icache_rdy) begin
            fetch_cnt++;
            if (exp_req.size() == 0) begin
                errors++;
                $display("cache request at %0t with no block expected", $time);
            end else begin
                got_req = exp_req.pop_front();
                check_val("o_icache_info.start_addr", got_req.start_addr,
                          o_icache_info.start_addr);
                check_val("o_icache_info.block_size", got_req.block_size,
                          o_icache_info.block_size);
            end
        end
        if (!rst && o_bpu_update) begin
            // a waiting update must not move
            if (held_vld) check_val("o_bpu_info", held_info, o_bpu_info);
            if (i_bpu_done) begin
                held_vld = 1'b0;
                if (exp_upd.size() == 0) begin
                    errors++;
                    $display("predictor update at %0t with none expected", $time);
                end else begin
                    got_upd = exp_upd.pop_front();
                    check_val("o_bpu_info.start_addr", got_upd.start_addr,
                              o_bpu_info.start_addr);
                    check_val("o_bpu_info.target_addr", got_upd.target_addr,
                              o_bpu_info.target_addr);
                    check_val("o_bpu_info.taken", got_upd.taken, o_bpu_info.taken);
                    check_val("o_bpu_info.new_counter", got_upd.new_counter,
                              o_bpu_info.new_counter);
                end
            end else begin
                held_vld  = 1'b1;
                held_info = o_bpu_info;
            end
        end else begin
            held_vld = 1'b0;
        end
    end

    initial begin
        rst             = 1'b1;
        i_pred_req      = 1'b0;
        i_pred_info     = '0;
        i_icache_rdy    = 1'b0;
        i_branch_wb_vld = '0;
        i_branch_wb     = '0;
        i_commit_vld    = 1'b0;
        i_commit_idx    = '0;
        i_squash_vld    = 1'b0;
        i_squash_idx    = '0;
        i_bpu_done      = 1'b0;
        cache_hold      = 1'b0;
        held_vld        = 1'b0;
        held_info       = '0;
        bpu_wait        = 0;
        fetch_cnt       = 0;
        checks          = 0;
        errors          = 0;
        // only mispredicted rows update the predictor, in table order
        for (int i = 0; i < NUM_BLK; i++) begin
            if (blk_table[i].mispred) begin
                exp_upd.push_back('{start_addr: blk_table[i].start_addr,
                                    target_addr: blk_table[i].target,
                                    taken: blk_table[i].taken,
                                    new_counter: next_ctr(blk_table[i].ctr,
                                                          blk_table[i].taken)});
            end
        end
        repeat (8) @(posedge clk);
        #10;
        rst = 1'b0;
        check_val("o_icache_req", 1'b0, o_icache_req);
        check_val("o_bpu_update", 1'b0, o_bpu_update);
        check_val("o_ftq_rdy", 1'b1, o_ftq_rdy);

        // fill the queue with nothing committed
        for (int i = 0; i < `FTQ_SIZE; i++) insert_blk(i);
        check_val("o_ftq_rdy", 1'b0, o_ftq_rdy);
        // resolve two slots per cycle, one per port
        for (int i = 0; i < `FTQ_SIZE; i += 2) begin
            set_wb(0, i);
            set_wb(1, i + 1);
            step();
            i_branch_wb_vld = '0;
        end
        // a ninth block waits while the queue is full
        i_pred_req = 1'b1;
        for (int i = 0; i < 3; i++) begin
            step();
            check_val("o_ftq_rdy", 1'b0, o_ftq_rdy);
        end
        wait_fetched(`FTQ_SIZE);
        commit_to(1);
        insert_blk(8);
        set_wb(0, 8);
        step();
        i_branch_wb_vld = '0;
        commit_to(5);
        insert_blk(9);
        set_wb(1, 9);
        step();
        i_branch_wb_vld = '0;
        wait_fetched(NUM_BLK);
        // rows 1 and 2 retired, so commit_ptr has left slot 2
        wait_updates(3);
        // wraps past slot 7 to retire the rest
        commit_to(2);
        wait_updates(0);
        check_val("o_bpu_update", 1'b0, o_bpu_update);
        check_val("o_ftq_rdy", 1'b1, o_ftq_rdy);

        // squash, queue starts at slot 2
        insert_blk(3);
        wait_fetched(NUM_BLK + 1);
        cache_hold = 1'b1;
        step();
        insert_blk(4);
        insert_blk(5);
        check_val("o_icache_req", 1'b1, o_icache_req);
        i_squash_vld = 1'b1;
        i_squash_idx = ftq_idx_t'(2);
        step();
        i_squash_vld = 1'b0;
        // younger unfetched blocks are gone
        exp_req.delete();
        check_val("o_icache_req", 1'b0, o_icache_req);
        insert_blk(7);
        cache_hold = 1'b0;
        wait_fetched(NUM_BLK + 2);
        // two clean retires, one cycle each
        commit_to(4);
        repeat (4) step();
        check_val("o_bpu_update", 1'b0, o_bpu_update);
        // no dropped block comes back after the rewind
        check_val("o_icache_req", 1'b0, o_icache_req);
        end_run();
    end

endmodule

`default_nettype wire
